//--- rtl/rename_pkg.sv
// Sizing for the rename stage
// Register file sizes are defaults that the top level passes down
package rename_pkg;

  // Architectural registers seen by software
  localparam int NUM_ARCH_REGS = 32;

  // Physical registers behind the alias table
  localparam int NUM_PHYS_REGS = 64;

  // Instructions renamed per group and fixed by the datapath
  localparam int RENAME_WIDTH = 2;

  // Bits to index n entries with a floor of one
  function automatic int idx_w(input int n);
    if (n > 1) begin
      return $clog2(n);
    end
    return 1;
  endfunction

  // Bits to hold a count from 0 up to n inclusive
  function automatic int cnt_w(input int n);
    if (n > 0) begin
      return $clog2(n + 1);
    end
    return 1;
  endfunction

endpackage

//--- rtl/uop_pkg.sv
// Micro-op encoding shared by decode and the testbench encoder
package uop_pkg;

  localparam int INSTR_W     = 32; // Instruction word
  localparam int OPC_W       = 4;  // Opcode field
  localparam int REG_FIELD_W = 5;  // Each register field

  // Field positions inside the instruction word
  localparam int OPC_HI  = 31;
  localparam int OPC_LO  = 28;
  localparam int DST_HI  = 27;
  localparam int DST_LO  = 23;
  localparam int SRC1_HI = 22;
  localparam int SRC1_LO = 18;
  localparam int SRC2_HI = 17;
  localparam int SRC2_LO = 13;

  // Operation classes with register use noted per entry
  typedef enum logic [OPC_W-1:0] {
    op_nop    = 4'd0, // No registers
    op_alu    = 4'd1, // dst, src1, src2
    op_alui   = 4'd2, // dst, src1
    op_load   = 4'd3, // dst, src1
    op_store  = 4'd4, // src1, src2
    op_branch = 4'd5  // src1, src2
  } opcode_e;

endpackage

//--- rtl/uop_decode.sv
`timescale 1ns/1ps

// Pulls register fields out of both words and works out which ones are live
module uop_decode (
  input  logic [rename_pkg::RENAME_WIDTH-1:0]                           instr_valid,
  input  logic [rename_pkg::RENAME_WIDTH-1:0][uop_pkg::INSTR_W-1:0]     instr,
  output uop_pkg::opcode_e [rename_pkg::RENAME_WIDTH-1:0]               op,
  output logic [rename_pkg::RENAME_WIDTH-1:0][uop_pkg::REG_FIELD_W-1:0] dst_idx,
  output logic [rename_pkg::RENAME_WIDTH-1:0][uop_pkg::REG_FIELD_W-1:0] src1_idx,
  output logic [rename_pkg::RENAME_WIDTH-1:0][uop_pkg::REG_FIELD_W-1:0] src2_idx,
  output logic [rename_pkg::RENAME_WIDTH-1:0]                           writes_dst,
  output logic [rename_pkg::RENAME_WIDTH-1:0]                           reads_src1,
  output logic [rename_pkg::RENAME_WIDTH-1:0]                           reads_src2
);

  // Unknown opcodes fold to nop
  function automatic uop_pkg::opcode_e decode_op(input logic [uop_pkg::OPC_W-1:0] raw);
    case (raw)
      uop_pkg::op_alu,
      uop_pkg::op_alui,
      uop_pkg::op_load,
      uop_pkg::op_store,
      uop_pkg::op_branch: return uop_pkg::opcode_e'(raw);
      default:            return uop_pkg::op_nop;
    endcase
  endfunction

  // Fields sit at the same positions in every format
  always_comb begin
    for (int s = 0; s < rename_pkg::RENAME_WIDTH; s++) begin
      op[s]       = decode_op(instr[s][uop_pkg::OPC_HI:uop_pkg::OPC_LO]);
      dst_idx[s]  = instr[s][uop_pkg::DST_HI:uop_pkg::DST_LO];
      src1_idx[s] = instr[s][uop_pkg::SRC1_HI:uop_pkg::SRC1_LO];
      src2_idx[s] = instr[s][uop_pkg::SRC2_HI:uop_pkg::SRC2_LO];
    end
  end

  // Register use per opcode
  always_comb begin
    for (int s = 0; s < rename_pkg::RENAME_WIDTH; s++) begin
      writes_dst[s] = 1'b0;
      reads_src1[s] = 1'b0;
      reads_src2[s] = 1'b0;
      case (op[s])
        uop_pkg::op_alu: begin
          writes_dst[s] = 1'b1;
          reads_src1[s] = 1'b1;
          reads_src2[s] = 1'b1;
        end
        uop_pkg::op_alui,
        uop_pkg::op_load: begin
          writes_dst[s] = 1'b1;
          reads_src1[s] = 1'b1;
        end
        uop_pkg::op_store,
        uop_pkg::op_branch: begin
          reads_src1[s] = 1'b1; // Address or compare operands
          reads_src2[s] = 1'b1;
        end
        default: ;
      endcase
      if (dst_idx[s] == '0) writes_dst[s] = 1'b0; // r0 is never renamed
      if (!instr_valid[s]) begin // Empty slot uses nothing
        writes_dst[s] = 1'b0;
        reads_src1[s] = 1'b0;
        reads_src2[s] = 1'b0;
      end
    end
  end

endmodule

//--- rtl/free_list.sv
`timescale 1ns/1ps

// Circular queue of free physical registers
// Up to two pops and two pushes per cycle land on the same edge
module free_list #(
  parameter int arch_regs = rename_pkg::NUM_ARCH_REGS,
  parameter int phys_regs = rename_pkg::NUM_PHYS_REGS,
  localparam int preg_w   = rename_pkg::idx_w(phys_regs)
) (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic [rename_pkg::RENAME_WIDTH-1:0]                pop,       // Per slot allocation
  input  logic [rename_pkg::RENAME_WIDTH-1:0]                push,      // Commit frees
  input  logic [rename_pkg::RENAME_WIDTH-1:0][preg_w-1:0]    push_preg,
  output logic [rename_pkg::RENAME_WIDTH-1:0][preg_w-1:0]    head_preg, // Next two free regs
  output logic                                               enough_free
);

  // Only registers beyond the architectural set ever sit in the queue
  localparam int depth   = phys_regs - arch_regs;
  localparam int ptr_w   = rename_pkg::idx_w(depth);
  localparam int count_w = rename_pkg::cnt_w(depth);

  logic [preg_w-1:0]  fifo_q [depth];
  logic [ptr_w-1:0]   head_q;   // Oldest free entry
  logic [ptr_w-1:0]   tail_q;   // Next slot to fill
  logic [count_w-1:0] count_q;  // Entries held
  logic [1:0]         n_pop;
  logic [1:0]         n_push;
  logic [ptr_w-1:0]   head_p1;  // Entry after head
  logic [ptr_w-1:0]   tail_p1;  // Entry after tail

  // Pointer advance with wrap at depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_add(input logic [ptr_w-1:0] ptr,
                                               input logic [1:0]       n);
    logic [ptr_w:0] sum;
    sum = ptr + n;
    if (sum >= depth) begin
      sum = sum - (ptr_w+1)'(depth);
    end
    return sum[ptr_w-1:0];
  endfunction

  assign n_pop   = {1'b0, pop[0]} + {1'b0, pop[1]};
  assign n_push  = {1'b0, push[0]} + {1'b0, push[1]};
  assign head_p1 = ptr_add(head_q, 2'd1);
  assign tail_p1 = ptr_add(tail_q, 2'd1);

  // Both head entries stay visible and the consumer decides how many it takes
  assign head_preg[0] = fifo_q[head_q];
  assign head_preg[1] = fifo_q[head_p1];

  assign enough_free = count_q >= count_w'(2); // Room for a full group

  // Pops and pushes land together
  // A pushed entry shows at the head no earlier than next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      head_q  <= '0;
      tail_q  <= '0; // Queue starts full so tail wraps onto head
      count_q <= count_w'(depth);
      for (int i = 0; i < depth; i++) begin
        fifo_q[i] <= preg_w'(arch_regs + i); // Ascending after the identity mappings
      end
    end else begin
      // Frees pack into consecutive entries with slot 0 first
      if (push[0]) begin
        fifo_q[tail_q] <= push_preg[0];
      end
      if (push[1]) begin
        fifo_q[push[0] ? tail_p1 : tail_q] <= push_preg[1];
      end
      head_q  <= ptr_add(head_q, n_pop);
      tail_q  <= ptr_add(tail_q, n_push);
      count_q <= count_q - count_w'(n_pop) + count_w'(n_push);
    end
  end

endmodule

//--- rtl/rename_table.sv
`timescale 1ns/1ps

// Register alias table with in-group bypass and the output register to the ROB
module rename_table #(
  parameter int arch_regs = rename_pkg::NUM_ARCH_REGS,
  parameter int phys_regs = rename_pkg::NUM_PHYS_REGS,
  localparam int w        = rename_pkg::RENAME_WIDTH,
  localparam int rf_w     = uop_pkg::REG_FIELD_W,
  localparam int preg_w   = rename_pkg::idx_w(phys_regs)
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [w-1:0]                 instr_valid,
  input  uop_pkg::opcode_e [w-1:0]     op,
  input  logic [w-1:0][rf_w-1:0]       dst_idx,
  input  logic [w-1:0][rf_w-1:0]       src1_idx,
  input  logic [w-1:0][rf_w-1:0]       src2_idx,
  input  logic [w-1:0]                 writes_dst,
  input  logic [w-1:0]                 reads_src1,
  input  logic [w-1:0]                 reads_src2,
  input  logic                         rob_stall,
  input  logic [w-1:0][preg_w-1:0]     head_preg,   // From free list
  input  logic                         enough_free,
  output logic                         ready,
  output logic [w-1:0]                 pop,
  output logic [w-1:0]                 out_valid,
  output uop_pkg::opcode_e [w-1:0]     out_op,
  output logic [w-1:0][preg_w-1:0]     out_src1_preg,
  output logic [w-1:0][preg_w-1:0]     out_src2_preg,
  output logic [w-1:0][preg_w-1:0]     out_dst_preg,
  output logic [w-1:0][preg_w-1:0]     out_old_dst_preg,
  output logic [w-1:0]                 out_writes_dst
);

  localparam int aw = rename_pkg::idx_w(arch_regs);

  logic [preg_w-1:0]        map_q [arch_regs]; // Arch to phys mapping
  logic                     accept;
  logic [w-1:0][preg_w-1:0] new_dst;           // Fresh register per slot
  logic [w-1:0][preg_w-1:0] src1_p;
  logic [w-1:0][preg_w-1:0] src2_p;
  logic [w-1:0][preg_w-1:0] old_dst;

  // Whole group or nothing so ready needs two free regs whatever the group uses
  assign ready  = !rob_stall && enough_free;
  assign accept = ready && |instr_valid;

  assign pop[0] = accept && writes_dst[0];
  assign pop[1] = accept && writes_dst[1];

  // Slot 1 takes the first head entry when slot 0 left it
  assign new_dst[0] = head_preg[0];
  assign new_dst[1] = writes_dst[0] ? head_preg[1] : head_preg[0];

  always_comb begin
    for (int s = 0; s < w; s++) begin
      src1_p[s]  = map_q[src1_idx[s][aw-1:0]];
      src2_p[s]  = map_q[src2_idx[s][aw-1:0]];
      old_dst[s] = map_q[dst_idx[s][aw-1:0]];
    end
    // Bypass slot 0's new mapping into slot 1
    if (writes_dst[0]) begin
      if (src1_idx[1] == dst_idx[0]) src1_p[1] = new_dst[0];
      if (src2_idx[1] == dst_idx[0]) src2_p[1] = new_dst[0];
      if (dst_idx[1] == dst_idx[0]) old_dst[1] = new_dst[0]; // Slot 1 then frees slot 0's reg
    end
    // Unused fields go out as zero
    for (int s = 0; s < w; s++) begin
      if (!reads_src1[s]) src1_p[s] = '0;
      if (!reads_src2[s]) src2_p[s] = '0;
      if (!writes_dst[s]) old_dst[s] = '0;
    end
  end

  // Table updates on the accept edge so the next group sees it
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < arch_regs; i++) begin
        map_q[i] <= preg_w'(i); // Identity map out of reset
      end
    end else if (accept) begin
      if (writes_dst[0]) map_q[dst_idx[0][aw-1:0]] <= new_dst[0];
      if (writes_dst[1]) map_q[dst_idx[1][aw-1:0]] <= new_dst[1]; // Later write wins
    end
  end

  // One cycle pulse per accepted group
  always_ff @(posedge clk) begin
    if (rst) out_valid <= '0;
    else     out_valid <= accept ? instr_valid : '0;
  end

  // Payload for the ROB loads on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      out_op           <= op;
      out_src1_preg    <= src1_p;
      out_src2_preg    <= src2_p;
      out_old_dst_preg <= old_dst;
      out_writes_dst   <= writes_dst;
      for (int s = 0; s < w; s++) begin
        out_dst_preg[s] <= writes_dst[s] ? new_dst[s] : '0;
      end
    end
  end

endmodule

//--- rtl/rename_stage.sv
`timescale 1ns/1ps

// Two-wide rename where decode feeds the alias table which draws from the free list
module rename_stage #(
  parameter int arch_regs = rename_pkg::NUM_ARCH_REGS,
  parameter int phys_regs = rename_pkg::NUM_PHYS_REGS,
  localparam int w        = rename_pkg::RENAME_WIDTH,
  localparam int preg_w   = rename_pkg::idx_w(phys_regs)
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [w-1:0]                  instr_valid,
  input  logic [w-1:0][uop_pkg::INSTR_W-1:0] instr,
  output logic                          ready,
  input  logic                          rob_stall,
  input  logic [w-1:0]                  commit_free_valid, // Released at commit
  input  logic [w-1:0][preg_w-1:0]      commit_free_preg,
  output logic [w-1:0]                  out_valid,
  output uop_pkg::opcode_e [w-1:0]      out_op,
  output logic [w-1:0][preg_w-1:0]      out_src1_preg,
  output logic [w-1:0][preg_w-1:0]      out_src2_preg,
  output logic [w-1:0][preg_w-1:0]      out_dst_preg,
  output logic [w-1:0][preg_w-1:0]      out_old_dst_preg,
  output logic [w-1:0]                  out_writes_dst
);

  // Decoded fields
  uop_pkg::opcode_e [w-1:0]               dec_op;
  logic [w-1:0][uop_pkg::REG_FIELD_W-1:0] dec_dst_idx;
  logic [w-1:0][uop_pkg::REG_FIELD_W-1:0] dec_src1_idx;
  logic [w-1:0][uop_pkg::REG_FIELD_W-1:0] dec_src2_idx;
  logic [w-1:0]                           dec_writes_dst;
  logic [w-1:0]                           dec_reads_src1;
  logic [w-1:0]                           dec_reads_src2;
  // Free list handshake
  logic [w-1:0][preg_w-1:0]               head_preg;
  logic                                   enough_free;
  logic [w-1:0]                           pop;

  uop_decode uop_decode_i (
    .instr_valid (instr_valid),
    .instr       (instr),
    .op          (dec_op),
    .dst_idx     (dec_dst_idx),
    .src1_idx    (dec_src1_idx),
    .src2_idx    (dec_src2_idx),
    .writes_dst  (dec_writes_dst),
    .reads_src1  (dec_reads_src1),
    .reads_src2  (dec_reads_src2)
  );

  rename_table #(.arch_regs(arch_regs), .phys_regs(phys_regs)) rename_table_i (
    .clk (clk), .rst (rst),
    .instr_valid (instr_valid), .op (dec_op),
    .dst_idx (dec_dst_idx), .src1_idx (dec_src1_idx), .src2_idx (dec_src2_idx),
    .writes_dst (dec_writes_dst), .reads_src1 (dec_reads_src1),
    .reads_src2 (dec_reads_src2), .rob_stall (rob_stall),
    .head_preg (head_preg), .enough_free (enough_free), .ready (ready), .pop (pop),
    .out_valid (out_valid), .out_op (out_op),
    .out_src1_preg (out_src1_preg), .out_src2_preg (out_src2_preg),
    .out_dst_preg (out_dst_preg), .out_old_dst_preg (out_old_dst_preg),
    .out_writes_dst (out_writes_dst)
  );

  // Commit frees go straight into the queue
  free_list #(.arch_regs(arch_regs), .phys_regs(phys_regs)) free_list_i (
    .clk (clk), .rst (rst), .pop (pop),
    .push (commit_free_valid), .push_preg (commit_free_preg),
    .head_preg (head_preg), .enough_free (enough_free)
  );

endmodule

//--- sim/rename_stage_tb.sv
`timescale 1ns/1ps

module rename_stage_tb;

  localparam int arch_regs = rename_pkg::NUM_ARCH_REGS;
  localparam int phys_regs = rename_pkg::NUM_PHYS_REGS;
  localparam int w         = rename_pkg::RENAME_WIDTH;
  localparam int preg_w    = rename_pkg::idx_w(phys_regs);

  logic                               clk;
  logic                               rst;
  logic [w-1:0]                       instr_valid;
  logic [w-1:0][uop_pkg::INSTR_W-1:0] instr;
  logic                               ready;
  logic                               rob_stall;
  logic [w-1:0]                       commit_free_valid;
  logic [w-1:0][preg_w-1:0]           commit_free_preg;
  logic [w-1:0]                       out_valid;
  uop_pkg::opcode_e [w-1:0]           out_op;
  logic [w-1:0][preg_w-1:0]           out_src1_preg;
  logic [w-1:0][preg_w-1:0]           out_src2_preg;
  logic [w-1:0][preg_w-1:0]           out_dst_preg;
  logic [w-1:0][preg_w-1:0]           out_old_dst_preg;
  logic [w-1:0]                       out_writes_dst;

  // Stimulus table with one entry per row
  string       row_name [$];
  logic [1:0]  row_valid [$];
  logic [31:0] row_w0 [$];
  logic [31:0] row_w1 [$];
  logic        row_stall [$];
  logic [1:0]  row_free [$];  // Commit free request per slot

  // Reference model state
  int model_map [arch_regs];  // Arch to phys
  int free_q [$];             // Free regs in queue order
  int dead_q [$];             // Replaced mappings that are safe to free

  // Expected outputs of the group accepted last cycle
  string      exp_name;
  logic [1:0] exp_valid;
  int         exp_op [w];
  int         exp_s1 [w];
  int         exp_s2 [w];
  int         exp_dst [w];
  int         exp_old [w];
  int         exp_wr [w];
  int         freed [w];      // Regs released this row or -1 for none

  logic [31:0] lcg_state;
  int          cycle_count;
  int          cycle_limit;

  rename_stage #(.arch_regs(arch_regs), .phys_regs(phys_regs)) rename_stage_i (
    .clk               (clk),
    .rst               (rst),
    .instr_valid       (instr_valid),
    .instr             (instr),
    .ready             (ready),
    .rob_stall         (rob_stall),
    .commit_free_valid (commit_free_valid),
    .commit_free_preg  (commit_free_preg),
    .out_valid         (out_valid),
    .out_op            (out_op),
    .out_src1_preg     (out_src1_preg),
    .out_src2_preg     (out_src2_preg),
    .out_dst_preg      (out_dst_preg),
    .out_old_dst_preg  (out_old_dst_preg),
    .out_writes_dst    (out_writes_dst)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;  // Low bits cycle too fast
  endfunction

  function automatic logic [31:0] encode(input logic [3:0] opc, input int dst,
                                         input int s1, input int s2);
    logic [31:0] word;
    word = '0;
    word[uop_pkg::OPC_HI:uop_pkg::OPC_LO]   = opc;
    word[uop_pkg::DST_HI:uop_pkg::DST_LO]   = 5'(dst);
    word[uop_pkg::SRC1_HI:uop_pkg::SRC1_LO] = 5'(s1);
    word[uop_pkg::SRC2_HI:uop_pkg::SRC2_LO] = 5'(s2);
    return word;
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] r;
    logic [3:0]  opc;
    r   = next_rand();
    opc = (r % 7 == 6) ? 4'hC : 4'(r % 7);  // Sometimes an undefined code
    return encode(opc, int'(r[12:8]), int'(r[17:13]), int'(r[22:18]));
  endfunction

  // Unlisted codes count as nop
  function automatic int op_of(input logic [31:0] word);
    int raw;
    raw = int'(word[uop_pkg::OPC_HI:uop_pkg::OPC_LO]);
    if (raw >= int'(uop_pkg::op_alu) && raw <= int'(uop_pkg::op_branch)) return raw;
    return int'(uop_pkg::op_nop);
  endfunction

  function automatic bit has_dst(input int op);
    return op == int'(uop_pkg::op_alu) || op == int'(uop_pkg::op_alui) ||
           op == int'(uop_pkg::op_load);
  endfunction

  function automatic bit has_src2(input int op);
    return op == int'(uop_pkg::op_alu) || op == int'(uop_pkg::op_store) ||
           op == int'(uop_pkg::op_branch);
  endfunction

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string row, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] row %s, %s: expected %0d, actual %0d", row, field, exp, act);
      abort_run();
    end
  endtask

  task automatic add_row(input string name, input logic [1:0] valid, input logic [31:0] w0,
                         input logic [31:0] w1, input logic stall, input logic [1:0] free);
    row_name.push_back(name);
    row_valid.push_back(valid);
    row_w0.push_back(w0);
    row_w1.push_back(w1);
    row_stall.push_back(stall);
    row_free.push_back(free);
  endtask

  task automatic build_table();
    add_row("reset_first", 2'b11, encode(uop_pkg::op_alu, 1, 2, 3),
            encode(uop_pkg::op_alu, 4, 5, 6), 1'b0, 2'b00);
    add_row("bypass_src", 2'b11, encode(uop_pkg::op_alu, 7, 1, 2),
            encode(uop_pkg::op_alu, 8, 7, 7), 1'b0, 2'b00);  // Slot 1 reads r7
    add_row("same_dst", 2'b11, encode(uop_pkg::op_alui, 9, 1, 0),
            encode(uop_pkg::op_load, 9, 2, 0), 1'b0, 2'b00);
    add_row("read_same_dst", 2'b11, encode(uop_pkg::op_alu, 10, 9, 9),
            encode(uop_pkg::op_store, 0, 9, 10), 1'b0, 2'b00);
    add_row("no_pop_st_br", 2'b11, encode(uop_pkg::op_store, 0, 1, 2),
            encode(uop_pkg::op_branch, 0, 3, 4), 1'b0, 2'b00);
    add_row("no_pop_r0", 2'b11, encode(uop_pkg::op_alu, 0, 1, 2),
            encode(uop_pkg::op_alui, 0, 3, 0), 1'b0, 2'b00);
    add_row("invalid_slot1", 2'b01, encode(uop_pkg::op_store, 0, 5, 6),
            encode(uop_pkg::op_alu, 11, 1, 2), 1'b0, 2'b00);
    add_row("invalid_slot0", 2'b10, encode(uop_pkg::op_alu, 12, 1, 2),
            encode(uop_pkg::op_branch, 0, 7, 8), 1'b0, 2'b00);
    add_row("after_skip", 2'b11, encode(uop_pkg::op_alu, 13, 8, 9),
            encode(uop_pkg::op_alu, 14, 13, 10), 1'b0, 2'b00);
    add_row("unknown_op", 2'b11, encode(4'hF, 15, 1, 2),
            encode(uop_pkg::op_nop, 16, 3, 4), 1'b0, 2'b00);
    // Run the queue dry so the last rows get refused
    for (int k = 0; k < 14; k++) begin
      add_row($sformatf("drain_%0d", k), 2'b11, encode(uop_pkg::op_alu, 1 + (2 * k) % 31, k, 1),
              encode(uop_pkg::op_alu, 1 + (2 * k + 1) % 31, 2, k), 1'b0, 2'b00);
    end
    add_row("free_one", 2'b00, '0, '0, 1'b0, 2'b01);
    add_row("free_two", 2'b00, '0, '0, 1'b0, 2'b11);
    add_row("reuse", 2'b11, encode(uop_pkg::op_alu, 5, 1, 2),
            encode(uop_pkg::op_alu, 6, 5, 3), 1'b0, 2'b00);
    add_row("refill", 2'b00, '0, '0, 1'b0, 2'b11);
    add_row("refill2", 2'b00, '0, '0, 1'b0, 2'b11);
    add_row("stall_hold", 2'b11, encode(uop_pkg::op_alu, 3, 1, 2),
            encode(uop_pkg::op_alu, 4, 3, 3), 1'b1, 2'b00);
    add_row("stall_free", 2'b11, encode(uop_pkg::op_alu, 3, 1, 2),
            encode(uop_pkg::op_load, 4, 3, 0), 1'b1, 2'b10);  // Slot 1 push alone
    add_row("after_stall", 2'b11, encode(uop_pkg::op_alu, 20, 3, 4),
            encode(uop_pkg::op_store, 0, 5, 6), 1'b0, 2'b00);
    for (int k = 0; k < 40; k++) begin
      add_row($sformatf("rand_%0d", k), 2'(next_rand()), random_word(), random_word(),
              next_rand() % 8 == 0, 2'(next_rand()));
    end
  endtask

  // Commit frees come only from mappings already replaced
  task automatic drive_row(input int r);
    for (int s = 0; s < w; s++) begin
      freed[s] = -1;
      if (row_free[r][s] && dead_q.size() > 0) freed[s] = dead_q.pop_front();
      commit_free_valid[s] = freed[s] >= 0;
      commit_free_preg[s]  = (freed[s] >= 0) ? preg_w'(freed[s]) : '0;
    end
    instr_valid = row_valid[r];
    instr[0]    = row_w0[r];
    instr[1]    = row_w1[r];
    rob_stall   = row_stall[r];
  endtask

  task automatic check_outputs();
    check_value(exp_name, "out_valid", exp_valid, out_valid);
    for (int s = 0; s < w; s++) begin
      if (exp_valid[s]) begin
        check_value(exp_name, $sformatf("out_op[%0d]", s), exp_op[s], out_op[s]);
        check_value(exp_name, $sformatf("out_src1_preg[%0d]", s), exp_s1[s], out_src1_preg[s]);
        check_value(exp_name, $sformatf("out_src2_preg[%0d]", s), exp_s2[s], out_src2_preg[s]);
        check_value(exp_name, $sformatf("out_dst_preg[%0d]", s), exp_dst[s], out_dst_preg[s]);
        check_value(exp_name, $sformatf("out_old_dst_preg[%0d]", s), exp_old[s],
                    out_old_dst_preg[s]);
        check_value(exp_name, $sformatf("out_writes_dst[%0d]", s), exp_wr[s],
                    out_writes_dst[s]);
      end
    end
  endtask

  // Slots renamed in order so slot 1 sees slot 0's new mapping
  task automatic predict_row(input int r);
    logic [31:0] word;
    int          op;
    int          d;
    bit          exp_ready;
    bit          accept;
    exp_ready = !row_stall[r] && free_q.size() >= 2;
    check_value(row_name[r], "ready", exp_ready, ready);
    accept    = exp_ready && row_valid[r] != 2'b00;
    exp_name  = row_name[r];
    exp_valid = accept ? row_valid[r] : 2'b00;
    for (int s = 0; s < w; s++) begin
      word = (s == 0) ? row_w0[r] : row_w1[r];
      op   = op_of(word);
      d    = int'(word[uop_pkg::DST_HI:uop_pkg::DST_LO]);
      if (accept && row_valid[r][s]) begin
        exp_op[s]  = op;
        exp_wr[s]  = has_dst(op) && d != 0;  // r0 keeps its mapping
        exp_s1[s]  = (op != 0) ? model_map[word[uop_pkg::SRC1_HI:uop_pkg::SRC1_LO]] : 0;
        exp_s2[s]  = has_src2(op) ? model_map[word[uop_pkg::SRC2_HI:uop_pkg::SRC2_LO]] : 0;
        exp_dst[s] = 0;
        exp_old[s] = 0;
        if (exp_wr[s] != 0) begin
          exp_dst[s]   = free_q.pop_front();
          exp_old[s]   = model_map[d];
          model_map[d] = exp_dst[s];
          dead_q.push_back(exp_old[s]);
        end
      end
    end
    // Frees go in behind anything still queued
    for (int s = 0; s < w; s++) begin
      if (freed[s] >= 0) free_q.push_back(freed[s]);
    end
  endtask

  initial begin
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: test did not finish within %0d cycles", cycle_limit);
    abort_run();
  end

  initial begin
    rst               = 1'b1;
    instr_valid       = '0;
    instr             = '0;
    rob_stall         = 1'b0;
    commit_free_valid = '0;
    commit_free_preg  = '0;
    lcg_state         = 32'd85;
    cycle_count       = 0;
    cycle_limit       = 0;
    build_table();
    cycle_limit = 2 * row_name.size() + 50;
    for (int i = 0; i < arch_regs; i++) model_map[i] = i;  // Identity after reset
    for (int i = arch_regs; i < phys_regs; i++) free_q.push_back(i);
    exp_name  = "reset";
    exp_valid = 2'b00;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < row_name.size(); r++) begin
      @(negedge clk);
      drive_row(r);
      #1;  // Let ready settle
      check_outputs();
      predict_row(r);
    end
    @(negedge clk);
    instr_valid       = '0;
    rob_stall         = 1'b0;
    commit_free_valid = '0;
    #1;
    check_outputs();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- rename_stage.f
rtl/rename_pkg.sv
rtl/uop_pkg.sv
rtl/uop_decode.sv
rtl/free_list.sv
rtl/rename_table.sv
rtl/rename_stage.sv
sim/rename_stage_tb.sv

//--- Bender.yml
package:
  name: rename_stage

sources:
  # Packages first, the modules use them by scoped names
  - rtl/rename_pkg.sv
  - rtl/uop_pkg.sv
  # Design, leaves before the top level
  - rtl/uop_decode.sv
  - rtl/free_list.sv
  - rtl/rename_table.sv
  - rtl/rename_stage.sv
  # Testbench
  - target: simulation
    files:
      - sim/rename_stage_tb.sv
